// File: dot_cfg_pkg.sv
// ====================
// Dot-product engine configuration
// Word width, vector length, pipeline latency and result buffer depth
// ====================

package dot_cfg_pkg;

   // ====================
   // Datapath
   // ====================

   // Bits per operand and per result, all arithmetic wraps at this width
   localparam int word_width = 16;

   // Words gathered into one vector, taken as adjacent pairs
   localparam int n_operands = 8;

   // Cycles from vec_valid to result_valid
   localparam int mac_latency = 4;

   // ====================
   // Flow control
   // ====================

   // Result slots in the output buffer, also the starting credit
   localparam int fifo_depth = 4;

   // Derived index widths
   localparam int idx_width = $clog2(n_operands);
   localparam int ptr_width = $clog2(fifo_depth);

endpackage

// File: dot_engine.f
dot_cfg_pkg.sv
dot_types_pkg.sv
operand_loader.sv
mac_pipeline.sv
result_fifo.sv
dot_engine.sv
dot_engine_props.sv
tb_dot_engine.sv

// File: dot_engine.sv
// ====================
// Streaming dot-product engine, top level
// Loader, MAC pipeline and result buffer between two four-phase ports
// ====================

`timescale 1ns/1ns

module dot_engine (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 in_req,
   input  dot_types_pkg::word_t in_data,
   output logic                 in_ack,
   output logic                 out_req,
   output dot_types_pkg::word_t out_data,
   input  logic                 out_ack
);

   // Loader to pipeline
   dot_types_pkg::operand_vec_t vec;
   logic                        vec_valid;

   // Pipeline to buffer
   dot_types_pkg::word_t        result;
   logic                        result_valid;

   // Buffer back to loader
   logic                        credit_return;

   // Input side, holds the credit count
   operand_loader u_loader (
      .clk           (clk),
      .rst           (rst),
      .in_req        (in_req),
      .in_data       (in_data),
      .in_ack        (in_ack),
      .credit_return (credit_return),
      .vec           (vec),
      .vec_valid     (vec_valid)
   );

   // Fixed-latency datapath
   mac_pipeline u_mac (
      .clk          (clk),
      .rst          (rst),
      .vec          (vec),
      .vec_valid    (vec_valid),
      .result       (result),
      .result_valid (result_valid)
   );

   // Output side
   result_fifo u_fifo (
      .clk           (clk),
      .rst           (rst),
      .result        (result),
      .result_valid  (result_valid),
      .out_req       (out_req),
      .out_data      (out_data),
      .out_ack       (out_ack),
      .credit_return (credit_return)
   );

endmodule

// File: dot_engine_props.sv
// ====================
// Dot-product engine checks
// Handshake, pipeline timing and credit bounds
// ====================

`timescale 1ns/1ns

module dot_engine_props (
   input logic                   clk,
   input logic                   rst,
   input logic                   in_req,
   input logic                   in_ack,
   input logic                   out_req,
   input logic                   out_ack,
   input dot_types_pkg::word_t   out_data,
   input logic                   vec_valid,
   input logic                   result_valid,
   input dot_types_pkg::credit_t credit_cnt
);

   // Output request holds with stable data until acknowledged
   a_out_req_hold: assert property (@(posedge clk) disable iff (rst)
      (out_req && !out_ack) |=> (out_req && $stable(out_data)))
      else $error("out_req dropped or out_data moved before out_ack");

   // Input ack stays up while the sender still holds req
   a_in_ack_hold: assert property (@(posedge clk) disable iff (rst)
      (in_ack && in_req) |=> in_ack)
      else $error("in_ack fell while in_req was still high");

   // Fixed pipeline latency
   a_mac_latency: assert property (@(posedge clk) disable iff (rst)
      result_valid == $past(vec_valid, dot_cfg_pkg::mac_latency))
      else $error("result_valid out of step with vec_valid");

   // Credit never exceeds the buffer size
   a_credit_bound: assert property (@(posedge clk) disable iff (rst)
      credit_cnt <= dot_types_pkg::credit_t'(dot_cfg_pkg::fifo_depth))
      else $error("credit count above fifo_depth");

endmodule

// File: dot_types_pkg.sv
// ====================
// Dot-product engine data types
// ====================

package dot_types_pkg;

   // One operand or one result
   typedef logic [dot_cfg_pkg::word_width-1:0] word_t;

   // Full operand vector, pairs are (0,1) (2,3) (4,5) (6,7)
   typedef word_t operand_vec_t [dot_cfg_pkg::n_operands];

   // Credit count
   // Must hold every value from 0 up to fifo_depth inclusive
   typedef logic [$clog2(dot_cfg_pkg::fifo_depth+1)-1:0] credit_t;

   // Buffer occupancy uses the same range as the credit count

endpackage

// File: mac_pipeline.sv
// ====================
// Multiply and adder-tree pipeline
// Four registered stages, every stage wraps modulo 2^word_width
// ====================

`timescale 1ns/1ns

module mac_pipeline (
   input  logic                        clk,
   input  logic                        rst,
   input  dot_types_pkg::operand_vec_t vec,
   input  logic                        vec_valid,
   output dot_types_pkg::word_t        result,
   output logic                        result_valid
);

   // Stage registers
   dot_types_pkg::operand_vec_t  in_r;
   dot_types_pkg::word_t         mult_r [dot_cfg_pkg::n_operands/2];
   dot_types_pkg::word_t         add_r  [dot_cfg_pkg::n_operands/4];
   dot_types_pkg::word_t         sum_r;

   // Valid travels beside the data
   logic [dot_cfg_pkg::mac_latency-1:0] valid_sr;

   // ====================
   // Datapath
   // ====================

   // Never stalls, so the data stages run every cycle
   always_ff @(posedge clk) begin
      // Stage 1, capture the vector
      in_r <= vec;

      // Stage 2, pair products truncated to word width
      for (int i = 0; i < dot_cfg_pkg::n_operands/2; i++) begin
         mult_r[i] <= in_r[2*i] * in_r[2*i+1];
      end

      // Stage 3, first adder level
      for (int i = 0; i < dot_cfg_pkg::n_operands/4; i++) begin
         add_r[i] <= mult_r[2*i] + mult_r[2*i+1];
      end

      // Stage 4, final adder
      sum_r <= add_r[0] + add_r[1];
   end

   assign result = sum_r;

   // ====================
   // Valid delay line
   // ====================

   // Bit 0 lines up with stage 1, top bit with the final sum
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_sr <= '0;
      end else begin
         valid_sr <= {valid_sr[dot_cfg_pkg::mac_latency-2:0], vec_valid};
      end
   end

   assign result_valid = valid_sr[dot_cfg_pkg::mac_latency-1];

endmodule

// File: operand_loader.sv
// ====================
// Operand loader
// Four-phase word receiver that gathers vectors and issues them on credit
// ====================

`timescale 1ns/1ns

module operand_loader (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        in_req,
   input  dot_types_pkg::word_t        in_data,
   output logic                        in_ack,
   input  logic                        credit_return,
   output dot_types_pkg::operand_vec_t vec,
   output logic                        vec_valid
);

   // Receive handshake states
   // Ack is high exactly while waiting for req to be released
   typedef enum logic {
      st_wait_req,
      st_wait_rel
   } state_t;

   state_t                                 state;
   logic [dot_cfg_pkg::idx_width-1:0]      idx;
   dot_types_pkg::credit_t                 credit_cnt;
   dot_types_pkg::operand_vec_t            vec_r;
   logic                                   last_word;
   logic                                   have_credit;
   logic                                   accept;
   logic                                   issue;

   // ====================
   // Accept decode
   // ====================

   // Slot index of the final word in a vector
   assign last_word   = (idx == dot_cfg_pkg::idx_width'(dot_cfg_pkg::n_operands - 1));
   assign have_credit = (credit_cnt != '0);

   // Ordinary words go straight through
   // Final word waits until a result slot is guaranteed downstream
   assign accept = (state == st_wait_req) && in_req && (!last_word || have_credit);
   assign issue  = accept && last_word;

   assign in_ack = (state == st_wait_rel);

   // ====================
   // Handshake FSM
   // ====================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= st_wait_req;
      end else begin
         case (state)
            st_wait_req: begin
               // Ack rises on the next edge
               if (accept) begin
                  state <= st_wait_rel;
               end
            end
            st_wait_rel: begin
               // Drop ack one cycle after req is seen low
               if (!in_req) begin
                  state <= st_wait_req;
               end
            end
            default: state <= st_wait_req;
         endcase
      end
   end

   // Word slot counter, wraps after the final word
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         idx <= '0;
      end else if (accept) begin
         if (last_word) begin
            idx <= '0;
         end else begin
            idx <= idx + 1'b1;
         end
      end
   end

   // Operand storage, written by slot
   // Last word lands on the same edge that raises vec_valid
   always_ff @(posedge clk) begin
      if (accept) begin
         vec_r[idx] <= in_data;
      end
   end

   assign vec = vec_r;

   // One-cycle issue strobe
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vec_valid <= 1'b0;
      end else begin
         vec_valid <= issue;
      end
   end

   // ====================
   // Credit counter
   // ====================

   // Issue and return may coincide, then the count holds
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         credit_cnt <= dot_types_pkg::credit_t'(dot_cfg_pkg::fifo_depth);
      end else begin
         case ({issue, credit_return})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

endmodule

// File: result_fifo.sv
// ====================
// Result buffer
// Circular buffer with four-phase sender and credit return on each pop
// ====================

`timescale 1ns/1ns

module result_fifo (
   input  logic                 clk,
   input  logic                 rst,
   input  dot_types_pkg::word_t result,
   input  logic                 result_valid,
   output logic                 out_req,
   output dot_types_pkg::word_t out_data,
   input  logic                 out_ack,
   output logic                 credit_return
);

   // Sender states
   // st_req drives out_req, st_rel waits for the receiver to drop ack
   typedef enum logic [1:0] {
      st_idle,
      st_req,
      st_rel
   } state_t;

   state_t                               state;
   dot_types_pkg::word_t                 mem [dot_cfg_pkg::fifo_depth];
   logic [dot_cfg_pkg::ptr_width-1:0]    wr_ptr;
   logic [dot_cfg_pkg::ptr_width-1:0]    rd_ptr;
   dot_types_pkg::credit_t               count;
   logic                                 push;
   logic                                 pop;

   // Credits upstream keep pushes from ever finding the buffer full
   assign push = result_valid;

   // Pop when the receiver acknowledges the head entry
   assign pop = (state == st_req) && out_ack;

   // ====================
   // Storage
   // ====================

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= result;
      end
   end

   // Head entry, stable until its pop
   assign out_data = mem[rd_ptr];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ====================
   // Sender FSM
   // ====================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               // Start a send once data is held and ack has settled low
               if ((count != '0) && !out_ack) begin
                  state <= st_req;
               end
            end
            st_req: begin
               if (out_ack) begin
                  state <= st_rel;
               end
            end
            st_rel: begin
               if (!out_ack) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   assign out_req = (state == st_req);

   // One credit back to the loader per delivered result
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         credit_return <= 1'b0;
      end else begin
         credit_return <= pop;
      end
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the dot-product engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

rm -rf obj_dir

# Compile the design, the checks and the testbench
if ! verilator --binary --timing --assert \
      --top-module tb_dot_engine \
      -f dot_engine.f \
      -o tb_dot_engine; then
   echo "Verilator build failed"
   exit 1
fi

# Run and keep the transcript
./obj_dir/tb_dot_engine > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "PASS: all tests" "$log_file"; then
   echo "Run result: pass"
   exit 0
else
   echo "Run result: fail"
   exit 1
fi

// File: tb_dot_engine.sv
// ====================
// Dot-product engine testbench
// Four-phase sender and receiver, LFSR operands, reference model
// ====================

`timescale 1ns/1ns

module tb_dot_engine;

   localparam int timeout_cycles = 400;
   localparam int stall_cycles   = 200;

   logic                 clk;
   logic                 rst;
   logic                 in_req;
   dot_types_pkg::word_t in_data;
   logic                 in_ack;
   logic                 out_req;
   dot_types_pkg::word_t out_data;
   logic                 out_ack;

   // Expected results in send order, and results as received
   dot_types_pkg::word_t exp_q [$];
   dot_types_pkg::word_t rx_q [$];
   logic [31:0]          lfsr_state;
   int                   vecs_done;

   dot_engine uut (
      .clk      (clk),
      .rst      (rst),
      .in_req   (in_req),
      .in_data  (in_data),
      .in_ack   (in_ack),
      .out_req  (out_req),
      .out_data (out_data),
      .out_ack  (out_ack)
   );

   bind dot_engine dot_engine_props props (
      .clk          (clk),
      .rst          (rst),
      .in_req       (in_req),
      .in_ack       (in_ack),
      .out_req      (out_req),
      .out_ack      (out_ack),
      .out_data     (out_data),
      .vec_valid    (vec_valid),
      .result_valid (result_valid),
      .credit_cnt   (u_loader.credit_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ====================
   // Helpers
   // ====================

   task automatic stop_on_failure();
      $display("FAIL: see errors above");
      $fatal(1, "Simulation stopped on first error");
   endtask

   // Next edge, then settle past it
   task automatic step_cycle();
      @(posedge clk);
      #2;
   endtask

   // Galois LFSR, taps x^32 x^22 x^2 x^1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
   endfunction

   // One bit per LFSR step
   task automatic next_random_word(output dot_types_pkg::word_t w);
      w = '0;
      for (int b = 0; b < dot_cfg_pkg::word_width; b++) begin
         w = {w[dot_cfg_pkg::word_width-2:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic make_random_vector(output dot_types_pkg::operand_vec_t v);
      for (int i = 0; i < dot_cfg_pkg::n_operands; i++) begin
         next_random_word(v[i]);
      end
   endtask

   // Sum of pair products, kept to the low word
   function automatic dot_types_pkg::word_t dot_reference(
      input dot_types_pkg::operand_vec_t v);
      logic [31:0] acc;
      acc = '0;
      for (int i = 0; i < dot_cfg_pkg::n_operands; i += 2) begin
         acc = acc + 32'(v[i]) * 32'(v[i+1]);
      end
      return acc[dot_cfg_pkg::word_width-1:0];
   endfunction

   // ====================
   // Four-phase sender
   // ====================

   task automatic send_word(input dot_types_pkg::word_t w);
      int n;
      in_data = w;
      in_req  = 1'b1;
      n = 0;
      while (!in_ack) begin
         step_cycle();
         n++;
         if (n > timeout_cycles) begin
            $display("Timeout waiting for in_ack to rise");
            stop_on_failure();
         end
      end
      in_req = 1'b0;
      n = 0;
      while (in_ack) begin
         step_cycle();
         n++;
         if (n > timeout_cycles) begin
            $display("Timeout waiting for in_ack to fall");
            stop_on_failure();
         end
      end
   endtask

   task automatic send_vector(input dot_types_pkg::operand_vec_t v);
      exp_q.push_back(dot_reference(v));
      for (int i = 0; i < dot_cfg_pkg::n_operands; i++) begin
         send_word(v[i]);
      end
      vecs_done++;
   endtask

   task automatic send_random_vectors(input int count);
      dot_types_pkg::operand_vec_t v;
      for (int k = 0; k < count; k++) begin
         make_random_vector(v);
         send_vector(v);
      end
   endtask

   // ====================
   // Four-phase receiver
   // ====================

   task automatic receive_results(input int count, input int stall);
      int n;
      dot_types_pkg::word_t got;
      for (int k = 0; k < count; k++) begin
         n = 0;
         while (!out_req) begin
            step_cycle();
            n++;
            if (n > timeout_cycles) begin
               $display("Timeout waiting for out_req to rise");
               stop_on_failure();
            end
         end
         repeat (stall) step_cycle();
         got     = out_data;
         out_ack = 1'b1;
         n = 0;
         while (out_req) begin
            step_cycle();
            n++;
            if (n > timeout_cycles) begin
               $display("Timeout waiting for out_req to fall after out_ack");
               stop_on_failure();
            end
         end
         out_ack = 1'b0;
         rx_q.push_back(got);
      end
   endtask

   task automatic expect_out_idle(input int cycles);
      for (int c = 0; c < cycles; c++) begin
         step_cycle();
         assert (!out_req) else begin
            $display("out_req rose with no result pending");
            stop_on_failure();
         end
      end
   endtask

   // Every expected value matched, no further result offered
   task automatic check_drained();
      step_cycle();
      step_cycle();
      assert (exp_q.size() == 0 && rx_q.size() == 0 && !out_req) else begin
         $display("Extra result offered or results unmatched after a test");
         stop_on_failure();
      end
   endtask

   // ====================
   // Comparing process
   // ====================

   initial begin : compare_results
      dot_types_pkg::word_t exp_val;
      dot_types_pkg::word_t got_val;
      forever begin
         @(posedge clk);
         #1;
         while (rx_q.size() > 0) begin
            got_val = rx_q.pop_front();
            if (exp_q.size() == 0) begin
               $display("Result received with no vector pending");
               stop_on_failure();
            end else begin
               exp_val = exp_q.pop_front();
               assert (got_val == exp_val) else begin
                  $display("** Error out_data expected %h got %h", exp_val, got_val);
                  stop_on_failure();
               end
            end
         end
      end
   end

   // ====================
   // Test sequence
   // ====================

   initial begin : run_tests
      dot_types_pkg::operand_vec_t v;
      rst        = 1'b1;
      in_req     = 1'b0;
      in_data    = '0;
      out_ack    = 1'b0;
      lfsr_state = 32'hdfee_6e6f;
      vecs_done  = 0;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;

      // Idle after reset, partial vector gives no result
      assert (!in_ack && !out_req) else begin
         $display("Handshake outputs not low after reset");
         stop_on_failure();
      end
      make_random_vector(v);
      exp_q.push_back(dot_reference(v));
      for (int i = 0; i < dot_cfg_pkg::n_operands - 1; i++) begin
         send_word(v[i]);
      end
      expect_out_idle(20);
      send_word(v[dot_cfg_pkg::n_operands-1]);
      receive_results(1, 0);
      check_drained();

      // Single vector
      send_random_vectors(1);
      receive_results(1, 0);
      expect_out_idle(10);
      check_drained();

      // Stream with a prompt receiver
      fork
         send_random_vectors(20);
         receive_results(20, 0);
      join
      expect_out_idle(10);
      check_drained();

      // Stalled receiver, sender must block on credit
      vecs_done = 0;
      fork
         send_random_vectors(10);
         begin
            repeat (stall_cycles) step_cycle();
            assert (vecs_done == dot_cfg_pkg::fifo_depth && in_req && !in_ack) else begin
               $display("Sender not blocked after fifo_depth vectors");
               stop_on_failure();
            end
            receive_results(10, 0);
         end
      join
      expect_out_idle(10);
      check_drained();

      // Wrapping products and sums
      for (int i = 0; i < dot_cfg_pkg::n_operands; i++) begin
         v[i] = 16'hffff;
      end
      fork
         begin
            send_vector(v);
            v = '{16'h8000, 16'h8000, 16'hfffe, 16'h0003,
                  16'h1234, 16'hff00, 16'h7fff, 16'h7fff};
            send_vector(v);
         end
         receive_results(2, 2);
      join
      check_drained();

      if (exp_q.size() == 0 && rx_q.size() == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("Results still pending at end of run");
         stop_on_failure();
      end
   end

endmodule
